// ==== rtl/exu_alu.sv ====
module exu_alu import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  exu_issue_t issue,
   output wb_req_t    alu_wb
);

   logic                  is_alu;
   alu_op_e               op;
   logic [4:0]            shamt;
   logic [XLEN-1:0]       result;
   logic                  wb_valid;
   logic [REG_ADDR_W-1:0] wb_rd;
   logic [XLEN-1:0]       wb_data;

   assign is_alu = issue.valid && (issue.unit == UNIT_ALU);
   assign op     = alu_op_e'(issue.op);
   assign shamt  = issue.b[4:0];

   always_comb begin
      case (op)
         ADD:     result = issue.a + issue.b;
         SUB:     result = issue.a - issue.b;
         SLT:     result = {{(XLEN-1){1'b0}}, $signed(issue.a) < $signed(issue.b)};
         SLTU:    result = {{(XLEN-1){1'b0}}, issue.a < issue.b};
         AND:     result = issue.a & issue.b;
         OR:      result = issue.a | issue.b;
         XOR:     result = issue.a ^ issue.b;
         NOR:     result = ~(issue.a | issue.b);
         SLL:     result = issue.a << shamt;
         SRL:     result = issue.a >> shamt;
         SRA:     result = $signed(issue.a) >>> shamt;
         default: result = '0;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= is_alu && issue.wen;
      end
   end

   always_ff @(posedge clk) begin
      if (is_alu) begin
         wb_rd   <= issue.rd;
         wb_data <= result;
      end
   end

   assign alu_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

   // every alu packet carries one of the eleven defined operations
   a_alu_op_legal: assert property (@(posedge clk) disable iff (!arst_n)
      is_alu |-> (issue.op <= SRA));

endmodule

// ==== rtl/exu_bru.sv ====
module exu_bru import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  exu_issue_t      issue,
   output logic            br_taken,
   output logic [XLEN-1:0] br_target,
   output wb_req_t         bru_wb
);

   logic                  is_bru;
   bru_op_e               op;
   logic                  cond;
   logic                  is_link;
   logic                  wb_valid;
   logic [REG_ADDR_W-1:0] wb_rd;
   logic [XLEN-1:0]       wb_data;

   assign is_bru  = issue.valid && (issue.unit == UNIT_BRU);
   assign op      = bru_op_e'(issue.op);
   assign is_link = (op == BL) || (op == JIRL);

   always_comb begin
      case (op)
         BEQ:     cond = issue.a == issue.b;
         BNE:     cond = issue.a != issue.b;
         BLT:     cond = $signed(issue.a) < $signed(issue.b);
         BGE:     cond = $signed(issue.a) >= $signed(issue.b);
         BLTU:    cond = issue.a < issue.b;
         BGEU:    cond = issue.a >= issue.b;
         BL,
         JIRL:    cond = 1'b1;
         default: cond = 1'b0;
      endcase
   end

   assign br_taken = is_bru && cond;
   // jirl is register relative, the rest pc relative
   assign br_target = (op == JIRL) ? issue.a + issue.offset : issue.pc + issue.offset;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wb_valid <= 1'b0;
      end else begin
         wb_valid <= is_bru && is_link && issue.wen;
      end
   end

   always_ff @(posedge clk) begin
      if (is_bru) begin
         wb_rd   <= issue.rd;
         wb_data <= issue.pc + 32'd4;
      end
   end

   assign bru_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

// ==== rtl/exu_bus_pkg.sv ====
package exu_bus_pkg;

   import exu_isa_pkg::*;

   // write-back sources, index order is priority order
   localparam int WB_SRC_N = 4;
   localparam int SRC_MUL  = 0;
   localparam int SRC_ALU  = 1;
   localparam int SRC_BRU  = 2;
   localparam int SRC_LSU  = 3;

   // data memory request, addr is the byte address
   typedef struct packed {
      logic [XLEN-1:0] addr;
      logic            wr;
      logic [3:0]      wstrb;
      logic [XLEN-1:0] wdata;
   } data_req_t;

   typedef struct packed {
      logic                  valid;
      logic [REG_ADDR_W-1:0] rd;
      logic [XLEN-1:0]       data;
   } wb_req_t;

endpackage

// ==== rtl/exu_isa_pkg.sv ====
package exu_isa_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;
   localparam int OP_W       = 4;

   typedef enum logic [1:0] {
      UNIT_ALU,
      UNIT_BRU,
      UNIT_MUL,
      UNIT_LSU
   } exu_unit_e;

   // shift amount comes from b[4:0]
   typedef enum logic [OP_W-1:0] {
      ADD, SUB, SLT, SLTU,
      AND, OR, XOR, NOR,
      SLL, SRL, SRA
   } alu_op_e;

   // BL and JIRL always taken, both link pc + 4
   typedef enum logic [OP_W-1:0] {
      BEQ, BNE, BLT, BGE, BLTU, BGEU, BL, JIRL
   } bru_op_e;

   typedef enum logic [OP_W-1:0] {
      MUL_LO, MULH_S, MULH_U
   } mul_op_e;

   typedef enum logic [OP_W-1:0] {
      LD_B, LD_H, LD_W, LD_BU, LD_HU, ST_B, ST_H, ST_W
   } lsu_op_e;

   typedef struct packed {
      logic                  valid;
      exu_unit_e             unit;
      logic [OP_W-1:0]       op;
      logic [XLEN-1:0]       a;
      // store data for stores
      logic [XLEN-1:0]       b;
      logic [XLEN-1:0]       offset;
      logic [XLEN-1:0]       pc;
      logic [REG_ADDR_W-1:0] rd;
      logic                  wen;
   } exu_issue_t;

endpackage

// ==== rtl/exu_lsu.sv ====
module exu_lsu import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  exu_issue_t      issue,
   output logic            data_req,
   output data_req_t       data_req_bus,
   input  logic            data_addr_ok,
   input  logic            data_data_ok,
   input  logic [XLEN-1:0] data_rdata,
   output wb_req_t         lsu_wb,
   output logic            lsu_busy,
   output logic            ale,
   output logic [XLEN-1:0] badv
);

   typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} lsu_state_e;

   lsu_state_e            state;
   logic                  is_lsu;
   lsu_op_e               op;
   logic [XLEN-1:0]       addr;
   logic [4:0]            st_shift;
   logic                  is_store;
   logic                  misaligned;
   logic [3:0]            wstrb;
   logic [XLEN-1:0]       st_mask;
   logic [XLEN-1:0]       st_data;
   data_req_t             req_q;
   lsu_op_e               ld_op;
   logic [REG_ADDR_W-1:0] ld_rd;
   logic                  ld_wen;
   logic [4:0]            ld_shift;
   logic [XLEN-1:0]       ld_raw;
   logic [XLEN-1:0]       ld_data;
   logic                  wb_valid;
   logic [XLEN-1:0]       wb_data;

   assign is_lsu   = issue.valid && (issue.unit == UNIT_LSU);
   assign op       = lsu_op_e'(issue.op);
   assign addr     = issue.a + issue.offset;
   assign st_shift = {addr[1:0], 3'b000};

   // size decode, natural alignment and byte lanes
   always_comb begin
      is_store   = 1'b0;
      misaligned = 1'b0;
      wstrb      = 4'b0000;
      st_mask    = '0;
      case (op)
         LD_H, LD_HU: begin
            misaligned = addr[0];
         end
         LD_W: begin
            misaligned = |addr[1:0];
         end
         ST_B: begin
            is_store = 1'b1;
            wstrb    = 4'b0001 << addr[1:0];
            st_mask  = 32'h0000_00ff;
         end
         ST_H: begin
            is_store   = 1'b1;
            misaligned = addr[0];
            wstrb      = 4'b0011 << addr[1:0];
            st_mask    = 32'h0000_ffff;
         end
         ST_W: begin
            is_store   = 1'b1;
            misaligned = |addr[1:0];
            wstrb      = 4'b1111;
            st_mask    = 32'hffff_ffff;
         end
         default: ;
      endcase
   end

   assign st_data = (issue.b & st_mask) << st_shift;

   // load lane extraction
   assign ld_shift = {req_q.addr[1:0], 3'b000};
   assign ld_raw   = data_rdata >> ld_shift;

   always_comb begin
      case (ld_op)
         LD_B:    ld_data = {{(XLEN-8){ld_raw[7]}}, ld_raw[7:0]};
         LD_BU:   ld_data = {{(XLEN-8){1'b0}}, ld_raw[7:0]};
         LD_H:    ld_data = {{(XLEN-16){ld_raw[15]}}, ld_raw[15:0]};
         LD_HU:   ld_data = {{(XLEN-16){1'b0}}, ld_raw[15:0]};
         default: ld_data = ld_raw;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= S_IDLE;
         ale      <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         ale      <= 1'b0;
         wb_valid <= 1'b0;
         case (state)
            S_IDLE: begin
               if (is_lsu && misaligned) begin
                  ale <= 1'b1;
               end else if (is_lsu) begin
                  state <= S_REQ;
               end
            end
            S_REQ: begin
               // a store is done once the address is taken
               if (data_addr_ok) begin
                  state <= req_q.wr ? S_IDLE : S_WAIT;
               end
            end
            S_WAIT: begin
               if (data_data_ok) begin
                  state    <= S_IDLE;
                  wb_valid <= ld_wen;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == S_IDLE && is_lsu) begin
         req_q  <= '{addr: addr, wr: is_store, wstrb: wstrb, wdata: st_data};
         ld_op  <= op;
         ld_rd  <= issue.rd;
         ld_wen <= issue.wen;
      end
      if (state == S_WAIT && data_data_ok) begin
         wb_data <= ld_data;
      end
   end

   assign data_req     = (state == S_REQ);
   assign data_req_bus = req_q;
   assign badv         = req_q.addr;
   assign lsu_wb       = '{valid: wb_valid, rd: ld_rd, data: wb_data};
   // busy through the load's write-back cycle
   assign lsu_busy     = (state != S_IDLE) || wb_valid;

   a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (data_req && !data_addr_ok) |=> (data_req && $stable(data_req_bus)));

endmodule

// ==== rtl/exu_mul.sv ====
module exu_mul import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic       clk,
   input  logic       arst_n,
   input  exu_issue_t issue,
   output wb_req_t    mul_wb
);

   logic                       is_mul;
   mul_op_e                    op;
   logic                       sign_mode;
   logic signed [XLEN:0]       a_ext;
   logic signed [XLEN:0]       b_ext;
   logic signed [2*XLEN+1:0]   prod_full;

   // stage 1
   logic                       s1_valid;
   logic                       s1_hi;
   logic [REG_ADDR_W-1:0]      s1_rd;
   logic [2*XLEN-1:0]          s1_prod;

   // stage 2
   logic                       wb_valid;
   logic [REG_ADDR_W-1:0]      wb_rd;
   logic [XLEN-1:0]            wb_data;

   assign is_mul    = issue.valid && (issue.unit == UNIT_MUL);
   assign op        = mul_op_e'(issue.op);
   assign sign_mode = (op == MULH_S);

   // 33-bit operands so one signed multiplier covers both modes
   assign a_ext     = {sign_mode & issue.a[XLEN-1], issue.a};
   assign b_ext     = {sign_mode & issue.b[XLEN-1], issue.b};
   assign prod_full = a_ext * b_ext;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         s1_valid <= 1'b0;
         wb_valid <= 1'b0;
      end else begin
         s1_valid <= is_mul && issue.wen;
         wb_valid <= s1_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (is_mul) begin
         s1_hi   <= (op != MUL_LO);
         s1_rd   <= issue.rd;
         s1_prod <= prod_full[2*XLEN-1:0];
      end
      if (s1_valid) begin
         wb_rd   <= s1_rd;
         wb_data <= s1_hi ? s1_prod[2*XLEN-1:XLEN] : s1_prod[XLEN-1:0];
      end
   end

   assign mul_wb = '{valid: wb_valid, rd: wb_rd, data: wb_data};

endmodule

// ==== rtl/exu_regfile.sv ====
module exu_regfile import exu_isa_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic [REG_ADDR_W-1:0] rs1_addr,
   input  logic [REG_ADDR_W-1:0] rs2_addr,
   output logic [XLEN-1:0]       rs1_data,
   output logic [XLEN-1:0]       rs2_data,
   input  logic                  rf_wen,
   input  logic [REG_ADDR_W-1:0] rf_waddr,
   input  logic [XLEN-1:0]       rf_wdata
);

   // r0 has no storage
   logic [XLEN-1:0] regs [1:2**REG_ADDR_W-1];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 1; i < 2**REG_ADDR_W; i++) begin
            regs[i] <= '0;
         end
      end else if (rf_wen && rf_waddr != '0) begin
         regs[rf_waddr] <= rf_wdata;
      end
   end

   assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
   assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== rtl/exu_top.sv ====
module exu_top import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  exu_issue_t            issue,

   // front end read ports
   input  logic [REG_ADDR_W-1:0] rs1_addr,
   input  logic [REG_ADDR_W-1:0] rs2_addr,
   output logic [XLEN-1:0]       rs1_data,
   output logic [XLEN-1:0]       rs2_data,

   output logic                  br_taken,
   output logic [XLEN-1:0]       br_target,
   output logic                  stall_req,
   output logic                  ale,
   output logic [XLEN-1:0]       badv,

   // data memory
   output logic                  data_req,
   output data_req_t             data_req_bus,
   input  logic                  data_addr_ok,
   input  logic                  data_data_ok,
   input  logic [XLEN-1:0]       data_rdata
);

   wb_req_t               alu_wb;
   wb_req_t               bru_wb;
   wb_req_t               mul_wb;
   wb_req_t               lsu_wb;
   logic                  lsu_busy;
   logic                  rf_wen;
   logic [REG_ADDR_W-1:0] rf_waddr;
   logic [XLEN-1:0]       rf_wdata;

   exu_alu u_alu (
      .clk       (clk      ),
      .arst_n    (arst_n   ),
      .issue     (issue    ),
      .alu_wb    (alu_wb   )
   );

   exu_bru u_bru (
      .clk       (clk      ),
      .arst_n    (arst_n   ),
      .issue     (issue    ),
      .br_taken  (br_taken ),
      .br_target (br_target),
      .bru_wb    (bru_wb   )
   );

   exu_mul u_mul (
      .clk       (clk      ),
      .arst_n    (arst_n   ),
      .issue     (issue    ),
      .mul_wb    (mul_wb   )
   );

   exu_lsu u_lsu (
      .clk          (clk         ),
      .arst_n       (arst_n      ),
      .issue        (issue       ),
      .data_req     (data_req    ),
      .data_req_bus (data_req_bus),
      .data_addr_ok (data_addr_ok),
      .data_data_ok (data_data_ok),
      .data_rdata   (data_rdata  ),
      .lsu_wb       (lsu_wb      ),
      .lsu_busy     (lsu_busy    ),
      .ale          (ale         ),
      .badv         (badv        )
   );

   // single write port shared by all four units
   exu_wb_arbiter u_wb_arbiter (
      .clk       (clk      ),
      .arst_n    (arst_n   ),
      .alu_wb    (alu_wb   ),
      .bru_wb    (bru_wb   ),
      .mul_wb    (mul_wb   ),
      .lsu_wb    (lsu_wb   ),
      .lsu_busy  (lsu_busy ),
      .rf_wen    (rf_wen   ),
      .rf_waddr  (rf_waddr ),
      .rf_wdata  (rf_wdata ),
      .stall_req (stall_req)
   );

   exu_regfile u_regfile (
      .clk       (clk      ),
      .arst_n    (arst_n   ),
      .rs1_addr  (rs1_addr ),
      .rs2_addr  (rs2_addr ),
      .rs1_data  (rs1_data ),
      .rs2_data  (rs2_data ),
      .rf_wen    (rf_wen   ),
      .rf_waddr  (rf_waddr ),
      .rf_wdata  (rf_wdata )
   );

endmodule

// ==== rtl/exu_wb_arbiter.sv ====
module exu_wb_arbiter import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic                  clk,
   input  logic                  arst_n,
   input  wb_req_t               alu_wb,
   input  wb_req_t               bru_wb,
   input  wb_req_t               mul_wb,
   input  wb_req_t               lsu_wb,
   input  logic                  lsu_busy,
   output logic                  rf_wen,
   output logic [REG_ADDR_W-1:0] rf_waddr,
   output logic [XLEN-1:0]       rf_wdata,
   output logic                  stall_req
);

   wb_req_t             req [WB_SRC_N];
   wb_req_t             cand [WB_SRC_N];
   wb_req_t             slot_q [WB_SRC_N];
   wb_req_t             win;
   logic [WB_SRC_N-1:0] slot_valid;
   logic [WB_SRC_N-1:0] gnt;

   assign req[SRC_MUL] = mul_wb;
   assign req[SRC_ALU] = alu_wb;
   assign req[SRC_BRU] = bru_wb;
   assign req[SRC_LSU] = lsu_wb;

   // a parked entry is older than a new one from the same unit
   always_comb begin
      for (int i = 0; i < WB_SRC_N; i++) begin
         cand[i] = slot_valid[i] ? slot_q[i] : req[i];
      end
   end

   // lowest index wins, so scan from the top down
   always_comb begin
      gnt = '0;
      win = '0;
      for (int i = WB_SRC_N - 1; i >= 0; i--) begin
         if (cand[i].valid) begin
            gnt    = '0;
            gnt[i] = 1'b1;
            win    = cand[i];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         slot_valid <= '0;
      end else begin
         for (int i = 0; i < WB_SRC_N; i++) begin
            if (!slot_valid[i] || gnt[i]) begin
               slot_valid[i] <= req[i].valid && (slot_valid[i] || !gnt[i]);
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < WB_SRC_N; i++) begin
         if (req[i].valid && (!slot_valid[i] || gnt[i])) begin
            slot_q[i] <= req[i];
         end
      end
   end

   assign rf_wen    = win.valid;
   assign rf_waddr  = win.rd;
   assign rf_wdata  = win.data;
   assign stall_req = (|slot_valid) || lsu_busy;

   // relies on the front end honouring stall_req
   for (genvar g = 0; g < WB_SRC_N; g++) begin : g_slot_chk
      a_no_overwrite: assert property (@(posedge clk) disable iff (!arst_n)
         (slot_valid[g] && !gnt[g]) |-> !req[g].valid);
   end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
   --top-module tb_exu -f vlog.f -o tb_exu
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

out=$(./obj_dir/tb_exu)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
   exit 1
fi

echo "$out" | grep -q "ALL CHECKS PASSED" || exit 1
exit 0

// ==== test/tb_exu.sv ====
module tb_exu import exu_isa_pkg::*, exu_bus_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   logic                  clk;
   logic                  arst_n;
   exu_issue_t            issue;
   logic [REG_ADDR_W-1:0] rs1_addr;
   logic [REG_ADDR_W-1:0] rs2_addr;
   logic [XLEN-1:0]       rs1_data;
   logic [XLEN-1:0]       rs2_data;
   logic                  br_taken;
   logic [XLEN-1:0]       br_target;
   logic                  stall_req;
   logic                  ale;
   logic [XLEN-1:0]       badv;
   logic                  data_req;
   data_req_t             data_req_bus;
   logic                  data_addr_ok;
   logic                  data_data_ok;
   logic [XLEN-1:0]       data_rdata;
   logic [2:0]            addr_delay;
   logic [2:0]            data_delay;

   logic [31:0] seed;
   logic [31:0] model_regs [32];
   logic [31:0] model_mem [256];

   exu_top u_dut (
      .clk          (clk         ),
      .arst_n       (arst_n      ),
      .issue        (issue       ),
      .rs1_addr     (rs1_addr    ),
      .rs2_addr     (rs2_addr    ),
      .rs1_data     (rs1_data    ),
      .rs2_data     (rs2_data    ),
      .br_taken     (br_taken    ),
      .br_target    (br_target   ),
      .stall_req    (stall_req   ),
      .ale          (ale         ),
      .badv         (badv        ),
      .data_req     (data_req    ),
      .data_req_bus (data_req_bus),
      .data_addr_ok (data_addr_ok),
      .data_data_ok (data_data_ok),
      .data_rdata   (data_rdata  )
   );

   tb_exu_mem u_mem (
      .clk          (clk         ),
      .arst_n       (arst_n      ),
      .data_req     (data_req    ),
      .data_req_bus (data_req_bus),
      .addr_delay   (addr_delay  ),
      .data_delay   (data_delay  ),
      .data_addr_ok (data_addr_ok),
      .data_data_ok (data_data_ok),
      .data_rdata   (data_rdata  )
   );

   always #20 clk = ~clk;

   function automatic logic [31:0] rand32();
      seed = seed * 32'd1664525 + 32'd1013904223;
      return seed ^ (seed >> 15);
   endfunction

   // same pattern as the memory responder
   function automatic logic [31:0] fill_word(input logic [7:0] idx);
      return {idx ^ 8'ha5, ~idx, idx + 8'h3c, idx};
   endfunction

   function automatic logic [31:0] alu_ref(input logic [3:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
      case (op)
         4'd0:    return a + b;
         4'd1:    return a - b;
         4'd2:    return {31'b0, $signed(a) < $signed(b)};
         4'd3:    return {31'b0, a < b};
         4'd4:    return a & b;
         4'd5:    return a | b;
         4'd6:    return a ^ b;
         4'd7:    return ~(a | b);
         4'd8:    return a << b[4:0];
         4'd9:    return a >> b[4:0];
         default: return 32'($signed(a) >>> b[4:0]);
      endcase
   endfunction

   function automatic logic [31:0] mul_ref(input logic [3:0] op, input logic [31:0] a,
                                           input logic [31:0] b);
      logic [63:0] p;
      if (op == 4'd1) begin
         p = 64'($signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b}));
      end else begin
         p = {32'b0, a} * {32'b0, b};
      end
      return (op == 4'd0) ? p[31:0] : p[63:32];
   endfunction

   task automatic stop_run();
      $display("CHECKS FAILED");
      $fatal(1);
   endtask

   task automatic report_timeout(input string what);
      $display("timeout while waiting for %s", what);
      stop_run();
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      assert (got === exp) else begin
         $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
         stop_run();
      end
   endtask

   task automatic write_model(input logic [4:0] rd, input logic wen, input logic [31:0] v);
      if (wen && rd != 5'd0) begin
         model_regs[rd] = v;
      end
   endtask

   // waits for a free front end, then presents one packet
   task automatic drive_issue(input exu_unit_e unit, input logic [3:0] op,
                              input logic [31:0] a, input logic [31:0] b,
                              input logic [31:0] offset, input logic [31:0] pc,
                              input logic [4:0] rd, input logic wen);
      int n;
      n = 0;
      while (stall_req) begin
         @(negedge clk);
         n++;
         if (n > 100) report_timeout("stall_req to fall before issue");
      end
      issue = '{valid: 1'b1, unit: unit, op: op, a: a, b: b, offset: offset,
                pc: pc, rd: rd, wen: wen};
   endtask

   task automatic step();
      @(negedge clk);
      issue.valid = 1'b0;
   endtask

   task automatic drain();
      int idle;
      int n;
      idle = 0;
      n = 0;
      while (idle < 4) begin
         @(negedge clk);
         idle = stall_req ? 0 : idle + 1;
         n++;
         if (n > 200) report_timeout("the pipeline to drain");
      end
   endtask

   task automatic check_regs();
      for (int i = 0; i < 32; i++) begin
         rs1_addr = 5'(i);
         rs2_addr = 5'(31 - i);
         #1;
         check_value($sformatf("rs1_data r%0d", i), rs1_data, model_regs[i]);
         check_value($sformatf("rs2_data r%0d", 31 - i), rs2_data, model_regs[31 - i]);
      end
      // back onto the falling edge before the next issue
      @(negedge clk);
   endtask

   task automatic run_alu(input int count);
      logic [3:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  rd;
      for (int i = 0; i < count; i++) begin
         op = 4'(rand32() % 11);
         a  = rand32();
         b  = rand32();
         rd = 5'(rand32());
         drive_issue(UNIT_ALU, op, a, b, '0, '0, rd, 1'b1);
         write_model(rd, 1'b1, alu_ref(op, a, b));
         step();
      end
   endtask

   task automatic run_bru(input int count);
      logic [3:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] off;
      logic [31:0] pc;
      logic [4:0]  rd;
      logic        taken;
      for (int i = 0; i < count; i++) begin
         op  = 4'(rand32() % 8);
         a   = rand32();
         b   = (rand32() % 4 == 0) ? a : rand32();
         off = {rand32() & 32'h0000_fffc};
         pc  = rand32() & 32'hffff_fffc;
         rd  = 5'(rand32());
         case (op)
            4'd0:    taken = (a == b);
            4'd1:    taken = (a != b);
            4'd2:    taken = ($signed(a) < $signed(b));
            4'd3:    taken = ($signed(a) >= $signed(b));
            4'd4:    taken = (a < b);
            4'd5:    taken = (a >= b);
            default: taken = 1'b1;
         endcase
         drive_issue(UNIT_BRU, op, a, b, off, pc, rd, 1'b1);
         #1;
         check_value("br_taken", 32'(br_taken), 32'(taken));
         check_value("br_target", br_target, (op == 4'd7) ? a + off : pc + off);
         if (op >= 4'd6) write_model(rd, 1'b1, pc + 32'd4);
         step();
      end
   endtask

   task automatic run_mul(input int count);
      logic [3:0]  op;
      logic [31:0] a;
      logic [31:0] b;
      logic [4:0]  rd;
      for (int i = 0; i < count; i++) begin
         op = 4'(rand32() % 3);
         a  = rand32();
         b  = rand32();
         rd = 5'(rand32());
         drive_issue(UNIT_MUL, op, a, b, '0, '0, rd, 1'b1);
         write_model(rd, 1'b1, mul_ref(op, a, b));
         step();
      end
   endtask

   // mul then alu one cycle later collide at the write port
   task automatic run_conflict(input logic [4:0] mul_rd, input logic [4:0] alu_rd);
      logic [31:0] a;
      logic [31:0] b;
      int          n;
      a = rand32();
      b = rand32();
      drive_issue(UNIT_MUL, 4'd0, a, b, '0, '0, mul_rd, 1'b1);
      write_model(mul_rd, 1'b1, mul_ref(4'd0, a, b));
      step();
      drive_issue(UNIT_ALU, 4'd0, b, a, '0, '0, alu_rd, 1'b1);
      write_model(alu_rd, 1'b1, a + b);
      step();
      n = 0;
      while (!stall_req) begin
         @(negedge clk);
         n++;
         if (n > 6) report_timeout("stall_req to rise on a write-port conflict");
      end
      drain();
      check_regs();
   endtask

   task automatic run_lsu(input int count);
      logic [3:0]  op;
      logic [31:0] addr;
      logic [31:0] off;
      logic [31:0] b;
      logic [31:0] word;
      logic [31:0] mask;
      logic [3:0]  strb;
      logic [4:0]  sh;
      logic [4:0]  rd;
      int          n;
      for (int i = 0; i < count; i++) begin
         op   = 4'(rand32() % 8);
         addr = rand32() & 32'h3ff;
         if (op == 4'd1 || op == 4'd4 || op == 4'd6) addr[0] = 1'b0;
         if (op == 4'd2 || op == 4'd7) addr[1:0] = 2'b00;
         off  = rand32() & 32'hff;
         b    = rand32();
         rd   = 5'(rand32());
         sh   = {addr[1:0], 3'b000};
         addr_delay = 3'(rand32());
         data_delay = 3'(rand32());
         drive_issue(UNIT_LSU, op, addr - off, b, off, '0, rd, 1'b1);
         step();
         n = 0;
         while (!data_req) begin
            @(negedge clk);
            n++;
            if (n > 10) report_timeout("data_req");
         end
         check_value("stall_req", 32'(stall_req), 32'd1);
         check_value("data_req_bus.addr", data_req_bus.addr, addr);
         check_value("data_req_bus.wr", 32'(data_req_bus.wr), 32'(op >= 4'd5));
         word = model_mem[addr[9:2]];
         if (op >= 4'd5) begin
            mask = (op == 4'd5) ? 32'hff : (op == 4'd6) ? 32'hffff : 32'hffff_ffff;
            strb = (op == 4'd5) ? 4'b0001 << addr[1:0] :
                   (op == 4'd6) ? 4'b0011 << addr[1:0] : 4'b1111;
            check_value("data_req_bus.wstrb", 32'(data_req_bus.wstrb), 32'(strb));
            check_value("data_req_bus.wdata", data_req_bus.wdata, (b & mask) << sh);
            model_mem[addr[9:2]] = (word & ~(mask << sh)) | ((b & mask) << sh);
         end else begin
            word = word >> sh;
            case (op)
               4'd0:    word = {{24{word[7]}}, word[7:0]};
               4'd1:    word = {{16{word[15]}}, word[15:0]};
               4'd3:    word = {24'b0, word[7:0]};
               4'd4:    word = {16'b0, word[15:0]};
               default: ;
            endcase
            write_model(rd, 1'b1, word);
         end
         // the front end stays held until the access has completed
         n = 0;
         while (stall_req) begin
            @(negedge clk);
            n++;
            if (n > 40) report_timeout("stall_req to fall after a memory access");
         end
         check_value("data_req", 32'(data_req), 32'd0);
         rs1_addr = rd;
         #1;
         check_value($sformatf("rs1_data r%0d", rd), rs1_data, model_regs[rd]);
         drain();
      end
      check_regs();
   endtask

   task automatic run_misaligned(input int count);
      logic [3:0]  op;
      logic [31:0] addr;
      int          n;
      for (int i = 0; i < count; i++) begin
         case (rand32() % 5)
            0:       op = 4'd1;
            1:       op = 4'd4;
            2:       op = 4'd2;
            3:       op = 4'd6;
            default: op = 4'd7;
         endcase
         addr = rand32() & 32'h3ff;
         if (op == 4'd2 || op == 4'd7) begin
            addr[1:0] = 2'(1 + rand32() % 3);
         end else begin
            addr[0] = 1'b1;
         end
         drive_issue(UNIT_LSU, op, addr - 32'h40, rand32(), 32'h40, '0, 5'(rand32()), 1'b1);
         step();
         n = 0;
         while (!ale) begin
            check_value("data_req", 32'(data_req), 32'd0);
            @(negedge clk);
            n++;
            if (n > 4) report_timeout("ale on a misaligned access");
         end
         check_value("badv", badv, addr);
         check_value("data_req", 32'(data_req), 32'd0);
         @(negedge clk);
         check_value("ale", 32'(ale), 32'd0);
         check_value("data_req", 32'(data_req), 32'd0);
      end
      drain();
      check_regs();
   endtask

   initial begin
      clk        = 1'b0;
      arst_n     = 1'b0;
      issue      = '0;
      rs1_addr   = '0;
      rs2_addr   = '0;
      addr_delay = '0;
      data_delay = '0;
      seed       = 32'd24897;
      for (int i = 0; i < 32; i++) model_regs[i] = '0;
      for (int i = 0; i < 256; i++) model_mem[i] = fill_word(8'(i));
      repeat (4) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      @(negedge clk);
      check_value("stall_req", 32'(stall_req), 32'd0);
      check_value("data_req", 32'(data_req), 32'd0);
      check_value("ale", 32'(ale), 32'd0);

      run_alu(40);
      drain();
      check_regs();
      run_bru(24);
      drain();
      check_regs();
      run_mul(24);
      drain();
      check_regs();
      run_conflict(5'd3, 5'd4);
      run_conflict(5'd7, 5'd7);
      run_lsu(40);
      run_misaligned(8);

      $display("ALL CHECKS PASSED");
      $finish;
   end

endmodule

// ==== test/tb_exu_mem.sv ====
module tb_exu_mem import exu_isa_pkg::*, exu_bus_pkg::*; (
   input  logic            clk,
   input  logic            arst_n,
   input  logic            data_req,
   input  data_req_t       data_req_bus,
   input  logic [2:0]      addr_delay,
   input  logic [2:0]      data_delay,
   output logic            data_addr_ok,
   output logic            data_data_ok,
   output logic [XLEN-1:0] data_rdata
);

   timeunit 1ns;
   timeprecision 1ps;

   // 1 KB of words, indexed by addr[9:2]
   logic [XLEN-1:0] mem [256];
   logic [2:0]      cnt;
   logic            pend;
   logic [7:0]      ld_idx;

   function automatic logic [31:0] fill_word(input logic [7:0] idx);
      return {idx ^ 8'ha5, ~idx, idx + 8'h3c, idx};
   endfunction

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = fill_word(8'(i));
      end
   end

   // responses change on the falling edge, stable at the rising one
   always @(negedge clk or negedge arst_n) begin
      if (!arst_n) begin
         data_addr_ok <= 1'b0;
         data_data_ok <= 1'b0;
         data_rdata   <= '0;
         cnt          <= '0;
         pend         <= 1'b0;
         ld_idx       <= '0;
      end else begin
         data_addr_ok <= 1'b0;
         data_data_ok <= 1'b0;
         if (pend) begin
            if (cnt >= data_delay) begin
               data_data_ok <= 1'b1;
               data_rdata   <= mem[ld_idx];
               pend         <= 1'b0;
               cnt          <= '0;
            end else begin
               cnt <= cnt + 3'd1;
            end
         end else if (data_req && !data_addr_ok) begin
            if (cnt >= addr_delay) begin
               data_addr_ok <= 1'b1;
               cnt          <= '0;
               if (data_req_bus.wr) begin
                  for (int b = 0; b < 4; b++) begin
                     if (data_req_bus.wstrb[b]) begin
                        mem[data_req_bus.addr[9:2]][8*b +: 8] <= data_req_bus.wdata[8*b +: 8];
                     end
                  end
               end else begin
                  pend   <= 1'b1;
                  ld_idx <= data_req_bus.addr[9:2];
               end
            end else begin
               cnt <= cnt + 3'd1;
            end
         end
      end
   end

endmodule

// ==== vlog.f ====
rtl/exu_isa_pkg.sv
rtl/exu_bus_pkg.sv
rtl/exu_alu.sv
rtl/exu_bru.sv
rtl/exu_mul.sv
rtl/exu_lsu.sv
rtl/exu_wb_arbiter.sv
rtl/exu_regfile.sv
rtl/exu_top.sv
test/tb_exu_mem.sv
test/tb_exu.sv
